/* rtl/lockstep_pkg.sv */
/*
  Shared types and constants for the lockstep checker.
  The core port structs are packed and compared as whole vectors,
  so any field added here is covered by the compare.
  Only MuBiOff disables; every other mubi_t value counts as enabled.
*/
package lockstep_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;

  // Start address used when nothing else is supplied
  parameter logic [AddrWidth-1:0] BootAddrDefault = 32'h0000_1000;

  ////////////////////////////////////////
  // Core ports
  ////////////////////////////////////////

  // 34-bit bus responses as seen by a core
  typedef struct packed {
    logic                 rsp_valid;
    logic                 rsp_err;
    logic [DataWidth-1:0] rsp_data;
  } core_in_t;

  // 66-bit request side of a core
  typedef struct packed {
    logic                 req_valid;
    logic                 req_we;
    logic [AddrWidth-1:0] req_addr;
    logic [DataWidth-1:0] req_wdata;
  } core_out_t;

  ////////////////////////////////////////
  // Multibit enable
  ////////////////////////////////////////

  typedef logic [3:0] mubi_t;

  // Complementary codes so a single bit flip never turns one into the other
  parameter mubi_t MuBiOn  = 4'hA;
  parameter mubi_t MuBiOff = 4'h5;

endpackage

/* rtl/shadow_reset_ctrl.sv */
/*
  Releases the shadow core reset LockstepOffset cycles after rst_ni,
  and enables comparison one cycle after that.
  LockstepOffset must be 2 or more.
  Two redundant counters guard the release; any disagreement is flagged
  on cnt_err_o for as long as it lasts.
*/
`timescale 1ns/1ns

module shadow_reset_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  output logic                shadow_rst_no,
  output lockstep_pkg::mubi_t cmp_en_o,
  output logic                cnt_err_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset + 1);
  localparam logic [CntW-1:0] CntMax = CntW'(LockstepOffset);
  localparam logic [CntW-1:0] CntSet = CntW'(LockstepOffset - 1);

  ////////////////////////////////////////
  // Redundant offset counters
  ////////////////////////////////////////

  logic [CntW-1:0] up_cnt_q;
  logic [CntW-1:0] dn_cnt_q;
  logic [CntW:0]   cnt_sum;
  logic            cnt_done;

  // Saturate once the up counter has covered the offset
  assign cnt_done = (up_cnt_q == CntMax);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_cnt_q <= '0;
      dn_cnt_q <= CntMax;
    end else if (!cnt_done) begin
      up_cnt_q <= up_cnt_q + 1'b1;
      dn_cnt_q <= dn_cnt_q - 1'b1;
    end
  end

  // The two counters always add up to the offset
  assign cnt_sum   = {1'b0, up_cnt_q} + {1'b0, dn_cnt_q};
  assign cnt_err_o = (cnt_sum != {1'b0, CntMax});

  ////////////////////////////////////////
  // Reset release and compare enable
  ////////////////////////////////////////

  lockstep_pkg::mubi_t rst_set_d;
  lockstep_pkg::mubi_t rst_set_q;
  lockstep_pkg::mubi_t cmp_en_q;

  assign rst_set_d = (up_cnt_q >= CntSet) ? lockstep_pkg::MuBiOn : lockstep_pkg::MuBiOff;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_set_q <= lockstep_pkg::MuBiOff;
      cmp_en_q  <= lockstep_pkg::MuBiOff;
    end else begin
      rst_set_q <= rst_set_d;
      cmp_en_q  <= rst_set_q;
    end
  end

  // Bit 1 is high in the On code and low in the Off code
  assign shadow_rst_no = rst_set_q[1];
  assign cmp_en_o      = cmp_en_q;

endmodule

/* rtl/delay_line.sv */
/*
  Fixed-latency shift register for any packed payload.
  Output is the input of Depth cycles earlier; Depth must be 1 or more.
  There is no handshake and every stage advances each cycle.
  All stages reset to zero.
*/
`timescale 1ns/1ns

module delay_line #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  output T     data_o
);

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  // Stage 0 takes the input and the last stage drives the output
  T [Depth-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        stage_q[i] <= T'('0);
      end
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

/* rtl/lockstep_core.sv */
/*
  Small accumulator core, instanced as the shadow copy of the main core.
  Issues sequential requests from boot_addr_i and sums good responses.
  An error response stops it for good until the next reset.
  boot_addr_i must be stable while rst_ni is low.
*/
`timescale 1ns/1ns

module lockstep_core (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [lockstep_pkg::AddrWidth-1:0]   boot_addr_i,
  input  lockstep_pkg::core_in_t               in_i,
  output lockstep_pkg::core_out_t              out_o,
  output logic                                 bus_err_o
);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  logic [lockstep_pkg::AddrWidth-1:0] addr_q;
  logic [lockstep_pkg::DataWidth-1:0] acc_q;
  logic                               err_q;
  logic                               we_q;

  logic rsp_ok;
  logic rsp_bad;

  // Nothing moves once an error has been seen
  assign rsp_ok  = in_i.rsp_valid & ~in_i.rsp_err & ~err_q;
  assign rsp_bad = in_i.rsp_valid & in_i.rsp_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= boot_addr_i;
      acc_q  <= '0;
      we_q   <= 1'b0;
    end else if (rsp_ok) begin
      addr_q <= addr_q + lockstep_pkg::AddrWidth'(4);
      acc_q  <= acc_q + in_i.rsp_data;
      // Alternate read and write requests
      we_q   <= ~we_q;
    end
  end

  // Sticky bus error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (rsp_bad) begin
      err_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Straight from registers so no input reaches an output in the same cycle
  assign out_o.req_valid = ~err_q;
  assign out_o.req_we    = we_q;
  assign out_o.req_addr  = addr_q;
  assign out_o.req_wdata = acc_q;
  assign bus_err_o       = err_q;

endmodule

/* rtl/output_compare.sv */
/*
  Compares the registered shadow outputs with the delayed main outputs.
  main_out_i must already be aligned to the shadow output register.
  The mismatch only counts while cmp_en_i is not MuBiOff; a counter
  error from the reset control always raises the major alert.
*/
`timescale 1ns/1ns

module output_compare (
  input  logic                    clk_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  lockstep_pkg::core_out_t main_out_i,
  input  lockstep_pkg::mubi_t     cmp_en_i,
  input  logic                    cnt_err_i,
  input  logic                    shadow_bus_err_i,
  output logic                    alert_major_o,
  output logic                    alert_core_o
);

  lockstep_pkg::core_out_t shadow_out_q;
  logic                    shadow_bus_err_q;
  logic                    cmp_active;
  logic                    outputs_mismatch;

  ////////////////////////////////////////
  // Shadow output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    shadow_out_q     <= shadow_out_i;
    shadow_bus_err_q <= shadow_bus_err_i;
  end

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  // Anything but the Off code keeps the compare running
  assign cmp_active       = (cmp_en_i != lockstep_pkg::MuBiOff);
  assign outputs_mismatch = cmp_active & (shadow_out_q != main_out_i);

  assign alert_major_o = outputs_mismatch | cnt_err_i;
  assign alert_core_o  = shadow_bus_err_q;

endmodule

/* rtl/lockstep_top.sv */
/*
  Lockstep checker around a shadow copy of the accumulator core.
  main_in_i and main_out_i are the main core's responses and requests
  of the same cycle. A difference shows on alert_major_o
  LockstepOffset+1 cycles later once comparison is on.
  LockstepOffset must be 2 or more; boot_addr_i must be held stable.
*/
`timescale 1ns/1ns

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [lockstep_pkg::AddrWidth-1:0] boot_addr_i,
  input  lockstep_pkg::core_in_t             main_in_i,
  input  lockstep_pkg::core_out_t            main_out_i,
  output logic                               alert_major_o,
  output logic                               alert_core_o
);

  logic                    shadow_rst_n;
  lockstep_pkg::mubi_t     cmp_en;
  logic                    cnt_err;
  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t shadow_out;
  lockstep_pkg::core_out_t main_out_dly;
  logic                    shadow_bus_err;

  ////////////////////////////////////////
  // Reset generation
  ////////////////////////////////////////

  shadow_reset_ctrl #(
    .LockstepOffset (LockstepOffset)
  ) u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en),
    .cnt_err_o     (cnt_err)
  );

  ////////////////////////////////////////
  // Delays
  ////////////////////////////////////////

  // Responses reach the shadow core LockstepOffset cycles late
  delay_line #(
    .T     (lockstep_pkg::core_in_t),
    .Depth (LockstepOffset)
  ) u_in_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_in_i),
    .data_o (shadow_in)
  );

  // One extra stage matches the shadow output register
  delay_line #(
    .T     (lockstep_pkg::core_out_t),
    .Depth (LockstepOffset + 1)
  ) u_out_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_out_i),
    .data_o (main_out_dly)
  );

  ////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////

  lockstep_core u_shadow_core (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_n),
    .boot_addr_i (boot_addr_i),
    .in_i        (shadow_in),
    .out_o       (shadow_out),
    .bus_err_o   (shadow_bus_err)
  );

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  output_compare u_cmp (
    .clk_i            (clk_i),
    .shadow_out_i     (shadow_out),
    .main_out_i       (main_out_dly),
    .cmp_en_i         (cmp_en),
    .cnt_err_i        (cnt_err),
    .shadow_bus_err_i (shadow_bus_err),
    .alert_major_o    (alert_major_o),
    .alert_core_o     (alert_core_o)
  );

endmodule

/* test/tb_lockstep_model.svh */
/*
  Reference model of the accumulator core, random source and output check.
  Included inside the testbench module, so names land in its scope.
  The check stops the run at the first mismatch.
*/
`ifndef TB_LOCKSTEP_MODEL_SVH
`define TB_LOCKSTEP_MODEL_SVH

// Architectural state of one accumulator core
typedef struct packed {
  logic [lockstep_pkg::AddrWidth-1:0] addr;
  logic [lockstep_pkg::DataWidth-1:0] acc;
  logic                               we;
  logic                               err;
} model_state_t;

int unsigned checks_done = 0;
logic [31:0] lcg_state   = 32'h263b_d34c;

// One clock of the core with outputs taken from the current state only
function automatic void core_step(
  input  model_state_t            cur,
  input  lockstep_pkg::core_in_t  rsp,
  output model_state_t            nxt,
  output lockstep_pkg::core_out_t out
);
  out.req_valid = ~cur.err;
  out.req_we    = cur.we;
  out.req_addr  = cur.addr;
  out.req_wdata = cur.acc;
  nxt = cur;
  if (rsp.rsp_valid && rsp.rsp_err) begin
    nxt.err = 1'b1;
  end else if (rsp.rsp_valid && !cur.err) begin
    nxt.addr = cur.addr + lockstep_pkg::AddrWidth'(4);
    nxt.acc  = cur.acc + rsp.rsp_data;
    nxt.we   = ~cur.we;
  end
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Low bits of the LCG are weak so callers take the upper ones for decisions
function automatic logic [31:0] next_random();
  lcg_state = lcg_next(lcg_state);
  return lcg_state;
endfunction

task automatic check_value(input string name, input logic actual, input logic expected);
  checks_done = checks_done + 1;
  if (actual !== expected) begin
    $display("FAIL at %0t ns: %s is %0b, expected %0b", $time, name, actual, expected);
    $display(">>> FAIL");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

`endif

/* test/tb_lockstep.sv */
/*
  Testbench for the lockstep checker, playing the main core.
  Built with the default offset of 2; timing checks follow that offset.
  Garbage on the main outputs is only driven while rst_ni is low.
*/
`timescale 1ns/1ns

module tb_lockstep;

  localparam int Offset        = 2;
  localparam int PhaseCycles   = 100;
  localparam int DrainCycles   = Offset + 3;
  // Clean run spans two phases and three more phases follow
  localparam int RunCycles     = 5 * PhaseCycles + DrainCycles;
  // Run length rounded up to whole hundreds
  localparam int TimeoutCycles = ((RunCycles + 99) / 100) * 100;

  logic                               clk_i;
  logic                               rst_ni;
  logic [lockstep_pkg::AddrWidth-1:0] boot_addr_i;
  lockstep_pkg::core_in_t             main_in_i;
  lockstep_pkg::core_out_t            main_out_i;
  logic                               alert_major_o;
  logic                               alert_core_o;

  `include "tb_lockstep_model.svh"

  model_state_t main_state;
  int           drv_cycle   = 1;
  int           err_cycle   = 0;
  int           cycle_count = 0;
  logic         fault_at [0:TimeoutCycles];

  lockstep_top #(
    .LockstepOffset (Offset)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr_i),
    .main_in_i     (main_in_i),
    .main_out_i    (main_out_i),
    .alert_major_o (alert_major_o),
    .alert_core_o  (alert_core_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Edges counted from the first one with rst_ni high
  initial begin : cycle_limit
    @(posedge rst_ni);
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $fatal(1, "Simulation timed out");
  end

  ////////////////////////////////////////
  // Expected alerts
  ////////////////////////////////////////

  // A fault in cycle n shows in cycle n+Offset+1; compare is on from Offset+2
  function automatic logic expected_major(input int cycle);
    int src;
    src = cycle - Offset - 1;
    if (cycle < Offset + 2 || src < 1) begin
      return 1'b0;
    end
    return fault_at[src];
  endfunction

  // Input delay, shadow core and compare register lie on the error path
  function automatic logic expected_core(input int cycle);
    return (err_cycle > 0) && (cycle >= err_cycle + Offset + 2);
  endfunction

  ////////////////////////////////////////
  // Main core
  ////////////////////////////////////////

  task automatic run_cycle(input logic rsp_err, input lockstep_pkg::core_out_t fault_mask);
    model_state_t            next_state;
    lockstep_pkg::core_out_t model_out;
    lockstep_pkg::core_in_t  rsp;
    logic [31:0]             r;
    r = next_random();
    rsp.rsp_valid = r[31] | rsp_err;
    rsp.rsp_err   = rsp_err;
    rsp.rsp_data  = next_random();
    core_step(main_state, rsp, next_state, model_out);
    main_in_i  = rsp;
    main_out_i = lockstep_pkg::core_out_t'(model_out ^ fault_mask);
    if (fault_mask != '0) begin
      fault_at[drv_cycle] = 1'b1;
    end
    if (rsp_err && err_cycle == 0) begin
      err_cycle = drv_cycle;
    end
    main_state = next_state;
    drv_cycle  = drv_cycle + 1;
    @(posedge clk_i);
    #1;
  endtask

  initial begin : stimulus
    lockstep_pkg::core_out_t fault_mask;
    logic [31:0]             r;
    for (int i = 0; i <= TimeoutCycles; i++) begin
      fault_at[i] = 1'b0;
    end
    main_state.addr = lockstep_pkg::BootAddrDefault;
    main_state.acc  = '0;
    main_state.we   = 1'b0;
    main_state.err  = 1'b0;
    rst_ni      = 1'b0;
    boot_addr_i = lockstep_pkg::BootAddrDefault;
    // Reset garbage never leaves the delay lines
    main_in_i   = {2'b11, next_random()};
    main_out_i  = {2'b11, next_random(), next_random()};
    @(posedge clk_i);
    #1;
    main_in_i  = {2'b11, next_random()};
    main_out_i = {2'b10, next_random(), next_random()};
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Clean run that also covers the window before compare is enabled
    for (int i = 0; i < 2 * PhaseCycles; i++) begin
      run_cycle(1'b0, '0);
    end

    // Single address bit flips
    for (int i = 0; i < PhaseCycles; i++) begin
      fault_mask = '0;
      if (i == 20 || i == 70) begin
        r = next_random();
        fault_mask.req_addr = lockstep_pkg::AddrWidth'(1) << r[20:16];
      end
      run_cycle(1'b0, fault_mask);
    end

    // Write data flip and then write enable flip
    for (int i = 0; i < PhaseCycles; i++) begin
      fault_mask = '0;
      if (i == 20) begin
        r = next_random();
        fault_mask.req_wdata = lockstep_pkg::DataWidth'(1) << r[24:20];
      end
      if (i == 60) begin
        fault_mask.req_we = 1'b1;
      end
      run_cycle(1'b0, fault_mask);
    end

    // Bus error freezes both cores alike
    for (int i = 0; i < PhaseCycles; i++) begin
      run_cycle(i == 10, '0);
    end

    for (int i = 0; i < DrainCycles; i++) begin
      run_cycle(1'b0, '0);
    end

    if (checks_done == 0) begin
      $display("No output checks were run");
      $display(">>> FAIL");
      $fatal(1, "Nothing was checked");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////

  // Sampled mid cycle and well after the drive
  initial begin : compare_outputs
    int m;
    @(posedge rst_ni);
    #4;
    forever begin
      m = cycle_count + 1;
      check_value($sformatf("alert_major_o in cycle %0d", m), alert_major_o,
                  expected_major(m));
      check_value($sformatf("alert_core_o in cycle %0d", m), alert_core_o,
                  expected_core(m));
      @(posedge clk_i);
      #5;
    end
  end

endmodule

/* lockstep.f */
+incdir+test
rtl/lockstep_pkg.sv
rtl/shadow_reset_ctrl.sv
rtl/delay_line.sv
rtl/lockstep_core.sv
rtl/output_compare.sv
rtl/lockstep_top.sv
test/tb_lockstep.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the lockstep checker testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f lockstep.f \
  --top-module tb_lockstep

# The log decides the verdict, so a fatal exit must not stop the script here
./obj_dir/Vtb_lockstep > sim.log 2>&1 || true

cat sim.log

if grep -qF ">>> FAIL" sim.log || ! grep -qF ">>> PASS" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation passed"
